// ==== Makefile ====
# Verilator build and run for the DZ receiver testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := dzReceiverTb
FILELIST  := sources.f
OBJDIR    := obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)

// ==== source/dzLinePkg.sv ====
/*
 * DZ line side types
 * Line number, received character and receive error flags
 */

`include "dzReceive_cfg.svh"

package dzLinePkg;

   // Number of one line, wide enough for every line
   typedef logic [$clog2(`DZ_LINES)-1:0] lineIndex;

   // One received character
   typedef logic [7:0] rxChar;

   // Receive errors reported by the line
   typedef struct packed
   {
      logic frameErr;
      logic parityErr;
   } rxErrors;

endpackage

// ==== source/dzReceive_cfg.svh ====
/*
 * DZ receive configuration
 * Line count, silo capacity and silo alarm threshold
 */

`ifndef DZ_RECEIVE_CFG_SVH
`define DZ_RECEIVE_CFG_SVH

// Eight asynchronous lines per multiplexer
`define DZ_LINES       8
// Silo capacity in characters
`define DZ_SILO_DEPTH  64
// Stores before the silo alarm fires
`define DZ_ALARM_COUNT 16

`endif

// ==== source/dzReceiver.sv ====
/*
 * DZ receiver
 * Eight line receivers, the line scanner and the shared receive silo
 */

`timescale 1ns/1ns

`include "dzReceive_cfg.svh"

module dzReceiver
   import dzLinePkg::*;
   import dzRegPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clr,
   input  logic                 masterEnable,
   input  logic                 alarmEnable,
   input  logic [`DZ_LINES-1:0] rxStrobe,
   input  rxChar                rxData [`DZ_LINES],
   input  rxErrors              rxErrs [`DZ_LINES],
   input  logic                 rbufRead,
   output logic                 rdone,
   output logic                 siloAlarm,
   output rbufWord              regRbuf
);

   // Per-line state
   logic [`DZ_LINES-1:0] lineFull;
   logic [`DZ_LINES-1:0] lineOvr;
   logic [`DZ_LINES-1:0] lineClr;
   rxChar                lineData [`DZ_LINES];
   rxErrors              lineErrs [`DZ_LINES];

   // Scanned line
   lineIndex             scanLine;
   logic                 scanFull;
   rxChar                scanData;
   rxErrors              scanErrs;
   logic                 scanOvr;

   // One holding register per line
   for (genvar i = 0; i < `DZ_LINES; i++)
   begin : g_line
      lineReceiver i_lineReceiver (
         .clk      (clk),
         .rst      (rst),
         .rxStrobe (rxStrobe[i]),
         .rxData   (rxData[i]),
         .rxErrs   (rxErrs[i]),
         .clear    (lineClr[i]),
         .full     (lineFull[i]),
         .data     (lineData[i]),
         .errs     (lineErrs[i]),
         .overrun  (lineOvr[i])
      );
   end

   lineScanner i_lineScanner (
      .clk          (clk),
      .rst          (rst),
      .masterEnable (masterEnable),
      .lineFull     (lineFull),
      .lineData     (lineData),
      .lineErrs     (lineErrs),
      .lineOvr      (lineOvr),
      .scanLine     (scanLine),
      .scanFull     (scanFull),
      .scanData     (scanData),
      .scanErrs     (scanErrs),
      .scanOvr      (scanOvr)
   );

   receiveSilo i_receiveSilo (
      .clk          (clk),
      .rst          (rst),
      .clr          (clr),
      .masterEnable (masterEnable),
      .alarmEnable  (alarmEnable),
      .scanLine     (scanLine),
      .scanFull     (scanFull),
      .scanData     (scanData),
      .scanErrs     (scanErrs),
      .scanOvr      (scanOvr),
      .lineClr      (lineClr),
      .rbufRead     (rbufRead),
      .rdone        (rdone),
      .siloAlarm    (siloAlarm),
      .regRbuf      (regRbuf)
   );

endmodule

// ==== source/dzRegPkg.sv ====
/*
 * DZ host register types
 * Silo entry layout and the receiver buffer word seen by the host
 */

package dzRegPkg;
   import dzLinePkg::*;

   // One stored character, 15 bits
   typedef struct packed
   {
      logic     overrun;
      logic     frameErr;
      logic     parityErr;
      // Always zero
      logic     reserved;
      lineIndex line;
      rxChar    data;
   } siloEntry;

   // Receiver buffer word, data valid on top
   typedef struct packed
   {
      logic     dataValid;
      siloEntry entry;
   } rbufWord;

endpackage

// ==== source/lineReceiver.sv ====
/*
 * Line receiver
 * Holds the last character of one line with its error flags,
 * a full flag and a line overrun flag
 */

`timescale 1ns/1ns

module lineReceiver
   import dzLinePkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    rxStrobe,
   input  rxChar   rxData,
   input  rxErrors rxErrs,
   input  logic    clear,
   output logic    full,
   output rxChar   data,
   output rxErrors errs,
   output logic    overrun
);

   //////////////////////////////
   // Control flags
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         full    <= 1'b0;
         overrun <= 1'b0;
      end
      else if (rxStrobe)
      begin
         // New character always lands
         full    <= 1'b1;
         // Overrun only if old one was never taken
         overrun <= clear ? 1'b0 : full;
      end
      else if (clear)
      begin
         full    <= 1'b0;
         overrun <= 1'b0;
      end
   end

   //////////////////////////////
   // Character and errors
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rxStrobe)
      begin
         data <= rxData;
         errs <= rxErrs;
      end
   end

endmodule

// ==== source/lineScanner.sv ====
/*
 * Line scanner
 * Round robin scan counter, presents the scanned line's state
 */

`timescale 1ns/1ns

`include "dzReceive_cfg.svh"

module lineScanner
   import dzLinePkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 masterEnable,
   input  logic [`DZ_LINES-1:0] lineFull,
   input  rxChar                lineData [`DZ_LINES],
   input  rxErrors              lineErrs [`DZ_LINES],
   input  logic [`DZ_LINES-1:0] lineOvr,
   output lineIndex             scanLine,
   output logic                 scanFull,
   output rxChar                scanData,
   output rxErrors              scanErrs,
   output logic                 scanOvr
);

   // Last line before wrapping
   localparam lineIndex lastLine = lineIndex'(`DZ_LINES - 1);

   // Scan counter, one line per cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         scanLine <= '0;
      else if (masterEnable)
      begin
         if (scanLine == lastLine)
            scanLine <= '0;
         else
            scanLine <= scanLine + 1'b1;
      end
   end

   // Scanned line out to the silo
   assign scanFull = lineFull[scanLine];
   assign scanData = lineData[scanLine];
   assign scanErrs = lineErrs[scanLine];
   assign scanOvr  = lineOvr[scanLine];

endmodule

// ==== source/receiveSilo.sv ====
/*
 * Receive silo
 * Circular buffer shared by all lines. Tracks depth and silo overrun,
 * raises the silo alarm and presents the receiver buffer word
 */

`timescale 1ns/1ns

`include "dzReceive_cfg.svh"

module receiveSilo
   import dzLinePkg::*;
   import dzRegPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clr,
   input  logic                 masterEnable,
   input  logic                 alarmEnable,
   input  lineIndex             scanLine,
   input  logic                 scanFull,
   input  rxChar                scanData,
   input  rxErrors              scanErrs,
   input  logic                 scanOvr,
   output logic [`DZ_LINES-1:0] lineClr,
   input  logic                 rbufRead,
   output logic                 rdone,
   output logic                 siloAlarm,
   output rbufWord              regRbuf
);

   localparam int ptrWidth   = $clog2(`DZ_SILO_DEPTH);
   localparam int depthWidth = $clog2(`DZ_SILO_DEPTH + 1);
   localparam int countWidth = $clog2(`DZ_ALARM_COUNT + 1);

   localparam logic [depthWidth-1:0] siloFull   = depthWidth'(`DZ_SILO_DEPTH);
   localparam logic [countWidth-1:0] alarmLevel = countWidth'(`DZ_ALARM_COUNT);

   // Pointer step with wrap, depth need not be a power of two
   function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
      if (ptr == ptrWidth'(`DZ_SILO_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   logic                  wr;
   logic                  rd;
   logic                  pop;
   logic                  store;
   logic                  drop;
   logic                  empty;
   logic                  full;
   logic [depthWidth-1:0] depth;
   logic [ptrWidth-1:0]   rdPtr;
   logic [ptrWidth-1:0]   wrPtr;
   logic                  siloOvr;
   logic [countWidth-1:0] alarmCount;
   logic                  dataValid;
   siloEntry              newEntry;
   siloEntry              headEntry;
   siloEntry              siloMem [`DZ_SILO_DEPTH];

   //////////////////////////////
   // Capture from the scanner
   //////////////////////////////

   // Scanned line holds a character
   assign wr = scanFull & masterEnable;

   // One-hot clear back to the scanned line
   always_comb
   begin
      lineClr = '0;
      if (wr)
         lineClr[scanLine] = 1'b1;
   end

   // Entry built straight from the scanner outputs
   always_comb
   begin
      newEntry.overrun   = scanOvr | siloOvr;
      newEntry.frameErr  = scanErrs.frameErr;
      newEntry.parityErr = scanErrs.parityErr;
      newEntry.reserved  = 1'b0;
      newEntry.line      = scanLine;
      newEntry.data      = scanData;
   end

   //////////////////////////////
   // Read strobe
   //////////////////////////////

   // Pop on the cycle after the host strobe
   always_ff @(posedge clk)
   begin
      if (rst)
         rd <= 1'b0;
      else
         rd <= rbufRead;
   end

   assign empty = (depth == '0);
   assign full  = (depth == siloFull);
   assign pop   = rd & ~empty;
   // A pop in the same cycle makes room
   assign store = wr & (~full | pop);
   // Character lost, line still cleared
   assign drop  = wr & ~store;

   //////////////////////////////
   // Pointers and depth
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst || clr)
      begin
         depth <= '0;
         rdPtr <= '0;
         wrPtr <= '0;
      end
      else
      begin
         if (store)
            wrPtr <= nextPtr(wrPtr);
         if (pop)
            rdPtr <= nextPtr(rdPtr);
         case ({store, pop})
            2'b10:   depth <= depth + 1'b1;
            2'b01:   depth <= depth - 1'b1;
            default: depth <= depth;
         endcase
      end
   end

   // Pending silo overrun, handed to the next stored entry
   always_ff @(posedge clk)
   begin
      if (rst || clr)
         siloOvr <= 1'b0;
      else if (drop)
         siloOvr <= 1'b1;
      else if (store)
         siloOvr <= 1'b0;
   end

   //////////////////////////////
   // Storage and head word
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (store)
         siloMem[wrPtr] <= newEntry;
      // Head reloaded every cycle
      headEntry <= siloMem[rdPtr];
   end

   // Data valid follows the head register
   // Dropped from the host strobe until the pop has settled
   always_ff @(posedge clk)
   begin
      if (rst || clr)
         dataValid <= 1'b0;
      else if (rbufRead || rd)
         dataValid <= 1'b0;
      else
         dataValid <= ~empty;
   end

   assign rdone   = dataValid;
   assign regRbuf = '{dataValid: dataValid, entry: headEntry};

   //////////////////////////////
   // Silo alarm
   //////////////////////////////

   // Counts stores, not depth; saturates at the alarm level
   always_ff @(posedge clk)
   begin
      if (rst || clr || rd || !alarmEnable)
         alarmCount <= '0;
      else if (store && alarmCount != alarmLevel)
         alarmCount <= alarmCount + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clr || rd || !alarmEnable)
         siloAlarm <= 1'b0;
      else if (alarmCount == alarmLevel)
         siloAlarm <= 1'b1;
   end

endmodule

// ==== sources.f ====
+incdir+source
source/dzLinePkg.sv
source/dzRegPkg.sv
source/lineReceiver.sv
source/lineScanner.sv
source/receiveSilo.sv
source/dzReceiver.sv
verif/dzReceiverTb.sv

// ==== verif/dzReceiverTb.sv ====
/*
 * DZ receiver testbench
 * Random characters into the lines, silo words read back and
 * compared against a reference, plus overrun, clear and alarm
 */

`timescale 1ns/1ns

`include "dzReceive_cfg.svh"

module dzReceiverTb
   import dzLinePkg::*;
   import dzRegPkg::*;
;

   // Characters per test, for the run limit
   localparam int charsTotal    = 20 + 8 + 2 + (`DZ_SILO_DEPTH + 4) + 2 * `DZ_ALARM_COUNT;
   localparam int timeoutCycles = charsTotal * (`DZ_LINES + 6) + 200;

   logic                 clk;
   logic                 rst;
   logic                 clr;
   logic                 masterEnable;
   logic                 alarmEnable;
   logic [`DZ_LINES-1:0] rxStrobe;
   rxChar                rxData [`DZ_LINES];
   rxErrors              rxErrs [`DZ_LINES];
   logic                 rbufRead;
   logic                 rdone;
   logic                 siloAlarm;
   rbufWord              regRbuf;

   // Expected words, oldest first
   rbufWord              expQ [$];
   logic                 readEnable;
   // Scan order mode for the all-lines burst
   logic                 anyOrder;
   logic                 orderStarted;
   lineIndex             nextLine;
   int unsigned          lcgState = 9297;
   int                   cycleCount;

   dzReceiver i_dzReceiver (
      .clk          (clk),
      .rst          (rst),
      .clr          (clr),
      .masterEnable (masterEnable),
      .alarmEnable  (alarmEnable),
      .rxStrobe     (rxStrobe),
      .rxData       (rxData),
      .rxErrs       (rxErrs),
      .rbufRead     (rbufRead),
      .rdone        (rdone),
      .siloAlarm    (siloAlarm),
      .regRbuf      (regRbuf)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // Random picks and reference
   //////////////////////////////

   function automatic int unsigned lcgNext();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   // Upper bits, low LCG bits are weak
   function automatic lineIndex pickLine();
      return lineIndex'(lcgNext() >> 16);
   endfunction

   function automatic rxChar pickChar();
      return rxChar'(lcgNext() >> 12);
   endfunction

   function automatic rxErrors pickErrs();
      return rxErrors'(lcgNext() >> 20);
   endfunction

   // Valid, overrun, frame, parity, zero, line, character
   function automatic rbufWord expectedWord(input lineIndex line, input rxChar ch,
                                            input rxErrors errs, input logic ovr);
      return rbufWord'({1'b1, ovr, errs.frameErr, errs.parityErr, 1'b0, line, ch});
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic checkRbuf(input rbufWord exp, input rbufWord act);
      if (act !== exp)
         reportFailure($sformatf("Fail at %0t ns: regRbuf expected %h, got %h",
                                 $time, exp, act));
   endtask

   task automatic checkScanLine(input lineIndex exp, input lineIndex act);
      if (act !== exp)
         reportFailure($sformatf("Fail at %0t ns: regRbuf line expected %0d, got %0d",
                                 $time, exp, act));
   endtask

   task automatic checkRdone(input logic exp);
      if (rdone !== exp)
         reportFailure($sformatf("Fail at %0t ns: rdone expected %b, got %b",
                                 $time, exp, rdone));
   endtask

   task automatic checkSiloAlarm(input logic exp);
      if (siloAlarm !== exp)
         reportFailure($sformatf("Fail at %0t ns: siloAlarm expected %b, got %b",
                                 $time, exp, siloAlarm));
   endtask

   // Pull the expected word of one line out of the queue
   task automatic takeLine(input lineIndex line, output rbufWord w);
      for (int i = 0; i < expQ.size(); i++)
      begin
         if (expQ[i].entry.line == line)
         begin
            w = expQ[i];
            expQ.delete(i);
            return;
         end
      end
      reportFailure($sformatf("Line %0d was read twice or was never sent", line));
   endtask

   //////////////////////////////
   // Host reader
   //////////////////////////////

   initial
   begin
      rbufWord expWord;
      rbufRead = 1'b0;
      forever
      begin
         @(negedge clk);
         if (readEnable && rdone)
         begin
            if (expQ.size() == 0)
               reportFailure("The silo presented a word that was never sent");
            if (anyOrder)
            begin
               // Lines must follow on from the first one read
               if (orderStarted)
                  checkScanLine(nextLine, regRbuf.entry.line);
               takeLine(regRbuf.entry.line, expWord);
               nextLine     = lineIndex'(regRbuf.entry.line + 1'b1);
               orderStarted = 1'b1;
            end
            else
               expWord = expQ.pop_front();
            checkRbuf(expWord, regRbuf);
            // Single-cycle read strobe
            rbufRead = 1'b1;
            @(negedge clk);
            rbufRead = 1'b0;
         end
      end
   end

   // Run limit
   initial
   begin
      cycleCount = 0;
      while (cycleCount < timeoutCycles)
      begin
         @(posedge clk);
         cycleCount++;
      end
      reportFailure($sformatf("The run did not finish within %0d clock cycles", cycleCount));
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   task automatic waitCycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Every queued word has been read
   task automatic waitDrained();
      while (expQ.size() != 0)
         @(negedge clk);
   endtask

   task automatic sendChar(input lineIndex line, input rxChar ch, input rxErrors errs);
      @(negedge clk);
      rxStrobe[line] = 1'b1;
      rxData[line]   = ch;
      rxErrs[line]   = errs;
      @(negedge clk);
      rxStrobe[line] = 1'b0;
   endtask

   // Random character, queued as expected, then left time to be scanned
   task automatic sendExpected(input logic ovr, input logic queued);
      lineIndex line;
      rxChar    ch;
      rxErrors  errs;
      line = pickLine();
      ch   = pickChar();
      errs = pickErrs();
      if (queued)
         expQ.push_back(expectedWord(line, ch, errs, ovr));
      sendChar(line, ch, errs);
   endtask

   initial
   begin
      lineIndex line;
      rxChar    ch;
      rxErrors  errs;
      rst          = 1'b1;
      clr          = 1'b0;
      masterEnable = 1'b0;
      alarmEnable  = 1'b0;
      rxStrobe     = '0;
      readEnable   = 1'b0;
      anyOrder     = 1'b0;
      orderStarted = 1'b0;
      nextLine     = '0;
      for (int i = 0; i < `DZ_LINES; i++)
      begin
         rxData[i] = '0;
         rxErrs[i] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst          = 1'b0;
      masterEnable = 1'b1;
      readEnable   = 1'b1;
      @(negedge clk);
      checkRdone(1'b0);
      checkSiloAlarm(1'b0);

      // Single characters, one at a time
      for (int i = 0; i < 20; i++)
      begin
         sendExpected(1'b0, 1'b1);
         waitDrained();
      end

      // All lines in one cycle, read back in scan order
      anyOrder     = 1'b1;
      orderStarted = 1'b0;
      @(negedge clk);
      for (int i = 0; i < `DZ_LINES; i++)
      begin
         ch        = pickChar();
         errs      = pickErrs();
         rxData[i] = ch;
         rxErrs[i] = errs;
         expQ.push_back(expectedWord(lineIndex'(i), ch, errs, 1'b0));
      end
      rxStrobe = '1;
      @(negedge clk);
      rxStrobe = '0;
      waitDrained();
      anyOrder = 1'b0;

      // Line overrun with the scanner held
      masterEnable = 1'b0;
      line         = pickLine();
      sendChar(line, pickChar(), pickErrs());
      ch   = pickChar();
      errs = pickErrs();
      expQ.push_back(expectedWord(line, ch, errs, 1'b1));
      sendChar(line, ch, errs);
      @(negedge clk);
      masterEnable = 1'b1;
      waitDrained();
      // Only the one word
      waitCycles(`DZ_LINES + 4);
      checkRdone(1'b0);

      // Fill past capacity, last two are dropped
      readEnable = 1'b0;
      for (int i = 0; i < `DZ_SILO_DEPTH + 2; i++)
      begin
         sendExpected(1'b0, i < `DZ_SILO_DEPTH);
         waitCycles(`DZ_LINES + 1);
      end
      readEnable = 1'b1;
      waitDrained();
      // Pending silo overrun lands on the next store
      sendExpected(1'b1, 1'b1);
      waitDrained();

      // Clear drops a waiting word
      readEnable = 1'b0;
      sendExpected(1'b0, 1'b0);
      while (!rdone)
         @(negedge clk);
      clr = 1'b1;
      @(negedge clk);
      clr = 1'b0;
      checkRdone(1'b0);

      // Alarm after the sixteenth store
      alarmEnable = 1'b1;
      for (int i = 0; i < `DZ_ALARM_COUNT; i++)
      begin
         sendExpected(1'b0, 1'b1);
         waitCycles(`DZ_LINES + 1);
         checkSiloAlarm(i == `DZ_ALARM_COUNT - 1);
      end
      // One read drops it
      readEnable = 1'b1;
      while (expQ.size() > `DZ_ALARM_COUNT - 1)
         @(negedge clk);
      readEnable = 1'b0;
      waitCycles(2);
      checkSiloAlarm(1'b0);
      readEnable = 1'b1;
      waitDrained();

      // Alarm disabled stays low
      alarmEnable = 1'b0;
      readEnable  = 1'b0;
      for (int i = 0; i < `DZ_ALARM_COUNT; i++)
      begin
         sendExpected(1'b0, 1'b1);
         waitCycles(`DZ_LINES + 1);
         checkSiloAlarm(1'b0);
      end
      readEnable = 1'b1;
      waitDrained();

      waitCycles(`DZ_LINES + 4);
      if (rdone !== 1'b0)
         reportFailure("The silo still holds a word after the last read");
      else
      begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule
